/* logic/core_bus_config.svh */
`ifndef CORE_BUS_CONFIG_SVH
`define CORE_BUS_CONFIG_SVH

// bus widths
`define CB_ADDR_W 32
`define CB_DATA_W 32

// instruction cache index bits, 16 one-word lines
`define CB_INDEX_W 4

// core-local timer region
`define CB_CLINT_BASE 32'h0200_0000
`define CB_CLINT_SIZE 32'h0001_0000

// mtime halves, as offsets from the region base
`define CB_MTIME_LO 32'h0000_BFF8
`define CB_MTIME_HI 32'h0000_BFFC

`endif

/* logic/core_bus_pkg.sv */
`include "core_bus_config.svh"

package core_bus_pkg;

	// byte address on the read bus
	typedef logic [`CB_ADDR_W-1:0] addr_t;

	// one bus data word
	typedef logic [`CB_DATA_W-1:0] data_t;

	// read response code, zero means OKAY
	typedef logic [1:0] resp_t;

	// what every read returns
	typedef struct packed {
		data_t data;
		resp_t resp;
	} rsp_t;

	// owner of the external read channel
	typedef enum logic [1:0] {
		IDLE,
		FETCH_WAIT,
		LOAD_WAIT
	} arb_state_t;

endpackage

/* logic/icache.sv */
`include "core_bus_config.svh"

module icache (
	input  logic                 clock,
	input  logic                 reset,
	input  logic                 fetch_valid,
	input  core_bus_pkg::addr_t  fetch_addr,
	output logic                 fetch_ready,
	output logic                 fetch_rvalid,
	output core_bus_pkg::rsp_t   fetch_rsp,
	input  logic                 fence_i,
	output logic                 refill_valid,
	output core_bus_pkg::addr_t  refill_addr,
	input  logic                 refill_ready,
	input  logic                 refill_rvalid,
	input  core_bus_pkg::rsp_t   refill_rsp
);
	import core_bus_pkg::*;

	localparam int OFFS_W = $clog2(`CB_DATA_W / 8);
	localparam int INDEX_W = `CB_INDEX_W;
	localparam int LINES = 1 << INDEX_W;
	localparam int TAG_W = `CB_ADDR_W - INDEX_W - OFFS_W;

	typedef logic [INDEX_W-1:0] index_t;
	typedef logic [TAG_W-1:0] tag_t;

	typedef enum logic [1:0] {
		IC_IDLE,
		IC_HIT,
		IC_REFILL_REQ,
		IC_REFILL_WAIT
	} ic_state_t;

	ic_state_t state;
	logic [LINES-1:0] line_valid;
	tag_t tag_mem [LINES];
	data_t data_mem [LINES];

	addr_t req_addr;
	data_t hit_data;
	logic fence_pending;

	index_t fetch_index;
	tag_t fetch_tag;
	index_t req_index;
	tag_t req_tag;
	logic fetch_fire;
	logic lookup_hit;
	logic fill;

	assign fetch_index = fetch_addr[OFFS_W +: INDEX_W];
	assign fetch_tag = fetch_addr[`CB_ADDR_W-1 -: TAG_W];
	assign req_index = req_addr[OFFS_W +: INDEX_W];
	assign req_tag = req_addr[`CB_ADDR_W-1 -: TAG_W];

	assign fetch_ready = (state == IC_IDLE);
	assign fetch_fire = fetch_valid && fetch_ready;
	assign lookup_hit = line_valid[fetch_index] && (tag_mem[fetch_index] == fetch_tag);

	// only a clean refill with no fence.i seen since the request may fill the line
	assign fill = (state == IC_REFILL_WAIT) && refill_rvalid
		&& (refill_rsp.resp == '0) && !fence_pending;

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= IC_IDLE;
		end else begin
			case (state)
				IC_IDLE: begin
					if (fetch_fire) begin
						state <= lookup_hit ? IC_HIT : IC_REFILL_REQ;
					end
				end
				IC_HIT: state <= IC_IDLE;
				IC_REFILL_REQ: begin
					if (refill_ready) begin
						state <= IC_REFILL_WAIT;
					end
				end
				IC_REFILL_WAIT: begin
					if (refill_rvalid) begin
						state <= IC_IDLE;
					end
				end
				default: state <= IC_IDLE;
			endcase
		end
	end

	// remembers a fence.i that lands while a refill is in flight
	always_ff @(posedge clock) begin
		if (reset || fetch_fire) begin
			fence_pending <= 1'b0;
		end else if (fence_i && (state != IC_IDLE)) begin
			fence_pending <= 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (reset || fence_i) begin
			line_valid <= '0;
		end else if (fill) begin
			line_valid[req_index] <= 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (fill) begin
			tag_mem[req_index] <= req_tag;
			data_mem[req_index] <= refill_rsp.data;
		end
	end

	always_ff @(posedge clock) begin
		if (fetch_fire) begin
			req_addr <= fetch_addr;
			hit_data <= data_mem[fetch_index];
		end
	end

	assign refill_valid = (state == IC_REFILL_REQ);
	assign refill_addr = req_addr;

	// a miss passes the refill response straight through, error or not
	assign fetch_rvalid = (state == IC_HIT) || ((state == IC_REFILL_WAIT) && refill_rvalid);

	always_comb begin
		if (state == IC_HIT) begin
			fetch_rsp.data = hit_data;
			fetch_rsp.resp = '0;
		end else begin
			fetch_rsp = refill_rsp;
		end
	end

	// a refill response only arrives for the refill in flight
	assert property (@(posedge clock) disable iff (reset)
		refill_rvalid |-> (state == IC_REFILL_WAIT));

endmodule

/* logic/clint_router.sv */
`include "core_bus_config.svh"

module clint_router (
	input  logic                 clock,
	input  logic                 reset,
	input  logic                 load_valid,
	input  core_bus_pkg::addr_t  load_addr,
	output logic                 load_ready,
	output logic                 load_rvalid,
	output core_bus_pkg::rsp_t   load_rsp,
	output logic                 fwd_valid,
	output core_bus_pkg::addr_t  fwd_addr,
	input  logic                 fwd_ready,
	input  logic                 fwd_rvalid,
	input  core_bus_pkg::rsp_t   fwd_rsp
);
	import core_bus_pkg::*;

	localparam addr_t CLINT_BASE = `CB_CLINT_BASE;
	localparam addr_t CLINT_SIZE = `CB_CLINT_SIZE;
	localparam addr_t MTIME_LO = `CB_MTIME_LO;
	localparam addr_t MTIME_HI = `CB_MTIME_HI;

	typedef enum logic [1:0] {
		CL_IDLE,
		CL_LOCAL,
		CL_FWD_REQ,
		CL_FWD_WAIT
	} cl_state_t;

	cl_state_t state;
	logic [2*`CB_DATA_W-1:0] mtime;
	addr_t req_addr;
	data_t local_data;
	data_t timer_data;
	addr_t load_offset;
	logic load_fire;

	function automatic logic in_clint(addr_t a);
		return (a >= CLINT_BASE) && ((a - CLINT_BASE) < CLINT_SIZE);
	endfunction

	assign load_ready = (state == CL_IDLE);
	assign load_fire = load_valid && load_ready;
	assign load_offset = load_addr - CLINT_BASE;

	always_ff @(posedge clock) begin
		if (reset) begin
			mtime <= '0;
		end else begin
			mtime <= mtime + 1;
		end
	end

	// other offsets in the region read as zero
	always_comb begin
		timer_data = '0;
		if (load_offset == MTIME_LO) begin
			timer_data = mtime[`CB_DATA_W-1:0];
		end else if (load_offset == MTIME_HI) begin
			timer_data = mtime[2*`CB_DATA_W-1:`CB_DATA_W];
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= CL_IDLE;
		end else begin
			case (state)
				CL_IDLE: begin
					if (load_fire) begin
						state <= in_clint(load_addr) ? CL_LOCAL : CL_FWD_REQ;
					end
				end
				CL_LOCAL: state <= CL_IDLE;
				CL_FWD_REQ: begin
					if (fwd_ready) begin
						state <= CL_FWD_WAIT;
					end
				end
				CL_FWD_WAIT: begin
					if (fwd_rvalid) begin
						state <= CL_IDLE;
					end
				end
				default: state <= CL_IDLE;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (load_fire) begin
			req_addr <= load_addr;
			local_data <= timer_data;
		end
	end

	assign fwd_valid = (state == CL_FWD_REQ);
	assign fwd_addr = req_addr;

	assign load_rvalid = (state == CL_LOCAL) || ((state == CL_FWD_WAIT) && fwd_rvalid);

	always_comb begin
		if (state == CL_LOCAL) begin
			load_rsp.data = local_data;
			load_rsp.resp = '0;
		end else begin
			load_rsp = fwd_rsp;
		end
	end

	assert property (@(posedge clock) disable iff (reset) fwd_valid |-> !in_clint(fwd_addr));

endmodule

/* logic/read_arbiter.sv */
module read_arbiter (
	input  logic                 clock,
	input  logic                 reset,
	input  logic                 refill_valid,
	input  core_bus_pkg::addr_t  refill_addr,
	output logic                 refill_ready,
	output logic                 refill_rvalid,
	output core_bus_pkg::rsp_t   refill_rsp,
	input  logic                 fwd_valid,
	input  core_bus_pkg::addr_t  fwd_addr,
	output logic                 fwd_ready,
	output logic                 fwd_rvalid,
	output core_bus_pkg::rsp_t   fwd_rsp,
	output logic                 mem_arvalid,
	output core_bus_pkg::addr_t  mem_araddr,
	input  logic                 mem_arready,
	input  logic                 mem_rvalid,
	input  core_bus_pkg::rsp_t   mem_rsp,
	output logic                 mem_rready
);
	import core_bus_pkg::*;

	arb_state_t state;
	logic ar_pending;
	addr_t ar_addr;
	logic grant_load;
	logic grant_fetch;

	// loads win a tie, fetch waits
	assign fwd_ready = (state == IDLE);
	assign refill_ready = (state == IDLE) && !fwd_valid;
	assign grant_load = fwd_valid && fwd_ready;
	assign grant_fetch = refill_valid && refill_ready;

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= IDLE;
		end else begin
			case (state)
				IDLE: begin
					if (grant_load) begin
						state <= LOAD_WAIT;
					end else if (grant_fetch) begin
						state <= FETCH_WAIT;
					end
				end
				FETCH_WAIT, LOAD_WAIT: begin
					if (mem_rvalid) begin
						state <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// address phase is issued the cycle after the grant
	always_ff @(posedge clock) begin
		if (reset) begin
			ar_pending <= 1'b0;
		end else if (grant_load || grant_fetch) begin
			ar_pending <= 1'b1;
		end else if (mem_arready) begin
			ar_pending <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (grant_load) begin
			ar_addr <= fwd_addr;
		end else if (grant_fetch) begin
			ar_addr <= refill_addr;
		end
	end

	assign mem_arvalid = ar_pending;
	assign mem_araddr = ar_addr;
	assign mem_rready = (state != IDLE);

	// single outstanding read, so the state names the owner of the response
	assign refill_rvalid = (state == FETCH_WAIT) && mem_rvalid;
	assign fwd_rvalid = (state == LOAD_WAIT) && mem_rvalid;
	assign refill_rsp = mem_rsp;
	assign fwd_rsp = mem_rsp;

	// read data only after the address phase of the outstanding read
	assert property (@(posedge clock) disable iff (reset)
		mem_rvalid |-> (state != IDLE) && !ar_pending);

	assert property (@(posedge clock) disable iff (reset)
		mem_arvalid && !mem_arready |=> mem_arvalid && $stable(mem_araddr));

endmodule

/* logic/mem_read_top.sv */
module mem_read_top (
	input  logic                 clock,
	input  logic                 reset,
	input  logic                 fetch_valid,
	input  core_bus_pkg::addr_t  fetch_addr,
	output logic                 fetch_ready,
	output logic                 fetch_rvalid,
	output core_bus_pkg::rsp_t   fetch_rsp,
	input  logic                 load_valid,
	input  core_bus_pkg::addr_t  load_addr,
	output logic                 load_ready,
	output logic                 load_rvalid,
	output core_bus_pkg::rsp_t   load_rsp,
	input  logic                 fence_i,
	output logic                 mem_arvalid,
	output core_bus_pkg::addr_t  mem_araddr,
	input  logic                 mem_arready,
	input  logic                 mem_rvalid,
	input  core_bus_pkg::rsp_t   mem_rsp,
	output logic                 mem_rready
);
	import core_bus_pkg::*;

	// fetch miss path
	logic refill_valid;
	addr_t refill_addr;
	logic refill_ready;
	logic refill_rvalid;
	rsp_t refill_rsp;

	// load path for everything outside the timer region
	logic fwd_valid;
	addr_t fwd_addr;
	logic fwd_ready;
	logic fwd_rvalid;
	rsp_t fwd_rsp;

	icache icache0 (
		.clock(clock),
		.reset(reset),
		.fetch_valid(fetch_valid),
		.fetch_addr(fetch_addr),
		.fetch_ready(fetch_ready),
		.fetch_rvalid(fetch_rvalid),
		.fetch_rsp(fetch_rsp),
		.fence_i(fence_i),
		.refill_valid(refill_valid),
		.refill_addr(refill_addr),
		.refill_ready(refill_ready),
		.refill_rvalid(refill_rvalid),
		.refill_rsp(refill_rsp)
	);

	clint_router clint0 (
		.clock(clock),
		.reset(reset),
		.load_valid(load_valid),
		.load_addr(load_addr),
		.load_ready(load_ready),
		.load_rvalid(load_rvalid),
		.load_rsp(load_rsp),
		.fwd_valid(fwd_valid),
		.fwd_addr(fwd_addr),
		.fwd_ready(fwd_ready),
		.fwd_rvalid(fwd_rvalid),
		.fwd_rsp(fwd_rsp)
	);

	read_arbiter arb0 (
		.clock(clock),
		.reset(reset),
		.refill_valid(refill_valid),
		.refill_addr(refill_addr),
		.refill_ready(refill_ready),
		.refill_rvalid(refill_rvalid),
		.refill_rsp(refill_rsp),
		.fwd_valid(fwd_valid),
		.fwd_addr(fwd_addr),
		.fwd_ready(fwd_ready),
		.fwd_rvalid(fwd_rvalid),
		.fwd_rsp(fwd_rsp),
		.mem_arvalid(mem_arvalid),
		.mem_araddr(mem_araddr),
		.mem_arready(mem_arready),
		.mem_rvalid(mem_rvalid),
		.mem_rsp(mem_rsp),
		.mem_rready(mem_rready)
	);

endmodule

/* sim/mem_read_tb.sv */
`include "core_bus_config.svh"

module mem_read_tb;
	import core_bus_pkg::*;

	localparam int N_DATA = 40;
	localparam int N_HIT = 20;
	localparam int N_FENCE = 8;
	localparam int N_LOAD = 24;
	localparam int N_MTIME = 8;
	localparam int N_ERR = 8;
	localparam int N_CONC = 40;
	localparam int TOTAL_OPS = N_DATA + 2*N_HIT + 2*N_FENCE + N_LOAD + 2*N_MTIME
		+ 3*N_ERR + 2*N_CONC;
	localparam int CYCLE = 4;
	localparam int TIMEOUT_CYCLES = TOTAL_OPS * 40 + 10;
	localparam int TAG_W = `CB_ADDR_W - `CB_INDEX_W - 2;
	localparam addr_t CLINT_BASE = `CB_CLINT_BASE;
	localparam addr_t MTIME_LO_ADDR = `CB_CLINT_BASE + `CB_MTIME_LO;
	localparam addr_t MTIME_HI_ADDR = `CB_CLINT_BASE + `CB_MTIME_HI;

	logic clock;
	logic reset;
	logic fetch_valid;
	addr_t fetch_addr;
	logic fetch_ready;
	logic fetch_rvalid;
	rsp_t fetch_rsp;
	logic load_valid;
	addr_t load_addr;
	logic load_ready;
	logic load_rvalid;
	rsp_t load_rsp;
	logic fence_i;
	logic mem_arvalid;
	addr_t mem_araddr;
	logic mem_arready;
	logic mem_rvalid;
	rsp_t mem_rsp;
	logic mem_rready;

	data_t mem_words [256];
	int ar_count;
	int fetch_sent;
	int fetch_seen;
	int load_sent;
	int load_seen;
	string test_name;
	int test_checks;
	int test_errors;
	int total_checks;
	int total_errors;

	// expected cache contents
	logic model_valid [1 << `CB_INDEX_W];
	logic [TAG_W-1:0] model_tag [1 << `CB_INDEX_W];

	mem_read_top dut0 (.*);

	initial clock = 1'b0;
	always #(CYCLE / 2) clock = ~clock;

	// memory word at bits [9:2], bit 12 selects an error
	function automatic rsp_t expected_mem(addr_t a);
		rsp_t r;
		r.data = mem_words[a[9:2]];
		r.resp = a[12] ? 2'd2 : 2'd0;
		return r;
	endfunction

	task automatic start_test(input string name);
		test_name = name;
		test_checks = 0;
		test_errors = 0;
	endtask

	task automatic finish_test();
		$display("test %s done: %0d checks, %0d errors", test_name, test_checks, test_errors);
		total_checks += test_checks;
		total_errors += test_errors;
	endtask

	task automatic check_rsp(input string what, input rsp_t expected, input rsp_t actual);
		test_checks++;
		assert (expected == actual) else begin
			test_errors++;
			$display("** Error %s %s: expected %h, actual %h", test_name, what, expected, actual);
		end
	endtask

	task automatic check_count(input string what, input int expected, input int actual);
		test_checks++;
		assert (expected == actual) else begin
			test_errors++;
			$display("** Error %s %s: expected %0d, actual %0d", test_name, what, expected, actual);
		end
	endtask

	task automatic check_true(input logic cond, input string what);
		test_checks++;
		assert (cond) else begin
			test_errors++;
			$display("%s failed: %s", test_name, what);
		end
	endtask

	task automatic pulse_fence();
		fence_i = 1'b1;
		@(negedge clock);
		fence_i = 1'b0;
		foreach (model_valid[i])
			model_valid[i] = 1'b0;
	endtask

	// issues one fetch, checks data and, if asked, the number of bus reads
	task automatic fetch_op(input addr_t a, input logic check_bus);
		logic [`CB_INDEX_W-1:0] idx;
		logic hit;
		rsp_t exp;
		rsp_t got;
		int ar_before;
		idx = a[2 +: `CB_INDEX_W];
		hit = model_valid[idx] && (model_tag[idx] == a[`CB_ADDR_W-1 -: TAG_W]);
		exp = expected_mem(a);
		ar_before = ar_count;
		fetch_valid = 1'b1;
		fetch_addr = a;
		fetch_sent++;
		do @(posedge clock); while (!fetch_ready);
		@(negedge clock);
		fetch_valid = 1'b0;
		do @(posedge clock); while (!fetch_rvalid);
		got = fetch_rsp;
		@(negedge clock);
		check_rsp($sformatf("fetch %h", a), exp, got);
		if (check_bus)
			check_count($sformatf("bus reads for fetch %h", a), hit ? 0 : 1, ar_count - ar_before);
		if (!hit && exp.resp == 2'd0) begin
			model_valid[idx] = 1'b1;
			model_tag[idx] = a[`CB_ADDR_W-1 -: TAG_W];
		end
	endtask

	task automatic load_op(input addr_t a, output rsp_t got);
		load_valid = 1'b1;
		load_addr = a;
		load_sent++;
		do @(posedge clock); while (!load_ready);
		@(negedge clock);
		load_valid = 1'b0;
		do @(posedge clock); while (!load_rvalid);
		got = load_rsp;
		@(negedge clock);
	endtask

	task automatic fetch_stream();
		for (int i = 0; i < N_CONC; i++) begin
			repeat ($urandom_range(0, 3)) @(negedge clock);
			fetch_op($urandom & 32'h0000_107C, 1'b0);
		end
	endtask

	task automatic load_stream();
		addr_t a;
		rsp_t exp;
		rsp_t got;
		for (int i = 0; i < N_CONC; i++) begin
			repeat ($urandom_range(0, 3)) @(negedge clock);
			if ($urandom_range(0, 3) == 0) begin
				// msip offset, reads as zero
				a = CLINT_BASE;
				exp = '0;
			end else begin
				a = $urandom & 32'h00FF_FFFC;
				exp = expected_mem(a);
			end
			load_op(a, got);
			check_rsp($sformatf("load %h", a), exp, got);
		end
	endtask

	// external memory, one read at a time with random stalls
	initial begin : memory_model
		addr_t rd_addr;
		mem_arready = 1'b0;
		mem_rvalid = 1'b0;
		mem_rsp = '0;
		forever begin
			@(negedge clock);
			if (!reset && mem_arvalid) begin
				repeat ($urandom_range(0, 3)) @(negedge clock);
				mem_arready = 1'b1;
				rd_addr = mem_araddr;
				@(negedge clock);
				mem_arready = 1'b0;
				ar_count++;
				repeat ($urandom_range(0, 3)) @(negedge clock);
				mem_rvalid = 1'b1;
				mem_rsp = expected_mem(rd_addr);
				@(posedge clock);
				check_true(mem_rready, "mem_rready was low when the read data returned");
				@(negedge clock);
				mem_rvalid = 1'b0;
				mem_rsp = '0;
			end
		end
	end

	always @(posedge clock) begin
		if (!reset) begin
			if (fetch_rvalid)
				fetch_seen++;
			if (load_rvalid)
				load_seen++;
		end
	end

	initial begin : watchdog
		#(TIMEOUT_CYCLES * CYCLE);
		$display("watchdog expired: run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("=== FAIL ===");
		$finish;
	end

	initial begin : main
		addr_t a;
		rsp_t got;
		data_t prev_lo;
		int ar_before;
		void'($urandom(51238));
		for (int i = 0; i < 256; i++)
			mem_words[i] = $urandom;
		foreach (model_valid[i])
			model_valid[i] = 1'b0;
		reset = 1'b1;
		fetch_valid = 1'b0;
		fetch_addr = '0;
		load_valid = 1'b0;
		load_addr = '0;
		fence_i = 1'b0;
		repeat (10) @(negedge clock);
		reset = 1'b0;

		start_test("fetch_data");
		check_true(fetch_ready && load_ready && !fetch_rvalid && !load_rvalid
			&& !mem_arvalid && !mem_rready, "handshake levels after reset are wrong");
		for (int i = 0; i < N_DATA; i++)
			fetch_op($urandom & 32'h00FF_EFFC, 1'b1);
		finish_test();

		start_test("fetch_hit");
		for (int i = 0; i < N_HIT; i++) begin
			a = $urandom & 32'h00FF_EFFC;
			fetch_op(a, 1'b1);
			fetch_op(a, 1'b1);
		end
		finish_test();

		start_test("fence_i");
		for (int i = 0; i < N_FENCE; i++) begin
			a = $urandom & 32'h00FF_EFFC;
			fetch_op(a, 1'b1);
			pulse_fence();
			fetch_op(a, 1'b1);
		end
		finish_test();

		start_test("loads");
		for (int i = 0; i < N_LOAD; i++) begin
			a = $urandom & 32'h00FF_EFFC;
			load_op(a, got);
			check_rsp($sformatf("load %h", a), expected_mem(a), got);
		end
		ar_before = ar_count;
		prev_lo = '0;
		for (int i = 0; i < N_MTIME; i++) begin
			load_op(MTIME_LO_ADDR, got);
			check_true(got.resp == 2'd0 && got.data > prev_lo, "mtime low did not increase");
			prev_lo = got.data;
			load_op(MTIME_HI_ADDR, got);
			check_rsp("mtime high", '0, got);
		end
		check_count("bus reads for timer loads", 0, ar_count - ar_before);
		finish_test();

		start_test("error_resp");
		for (int i = 0; i < N_ERR; i++) begin
			a = ($urandom & 32'h00FF_FFFC) | 32'h0000_1000;
			fetch_op(a, 1'b1);
			fetch_op(a, 1'b1);
			load_op(a, got);
			check_rsp($sformatf("load %h", a), expected_mem(a), got);
		end
		finish_test();

		start_test("concurrent");
		fork
			fetch_stream();
			load_stream();
		join
		repeat (4) @(negedge clock);
		check_count("fetch responses", fetch_sent, fetch_seen);
		check_count("load responses", load_sent, load_seen);
		finish_test();

		$display("all tests: %0d checks, %0d errors", total_checks, total_errors);
		if (total_errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

/* fetch_load_bus.f */
+incdir+logic
logic/core_bus_pkg.sv
logic/icache.sv
logic/clint_router.sv
logic/read_arbiter.sv
logic/mem_read_top.sv
sim/mem_read_tb.sv

/* run_sim.sh */
#!/bin/sh
# builds the read-path testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert \
	--top-module mem_read_tb \
	-f fetch_load_bus.f \
	&& ./obj_dir/Vmem_read_tb > sim.log 2>&1 \
	|| echo "build or simulation ended with an error status"

cat sim.log 2>/dev/null

grep -qx "=== PASS ===" sim.log 2>/dev/null \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
